// File: hw/accu_cpu_macros.svh
`ifndef ACCU_CPU_MACROS_SVH
`define ACCU_CPU_MACROS_SVH

// Data and address width
`define ACCU_WIDTH 8

`define ACCU_MEM_DEPTH 256

// Stack grows downward from here
`define ACCU_STACK_TOP 8'hF0
`define ACCU_STACK_UNIT 1

// Longest instruction, [imm] source and [imm] destination with a memory write
`define ACCU_MAX_INSTR_CYCLES 20

`endif

// File: hw/accu_cpu_pkg.sv
`include "accu_cpu_macros.svh"

package accu_cpu_pkg;

  typedef logic [`ACCU_WIDTH-1:0] byte_t;

  typedef enum logic [2:0] {
    MOV, ADD, PUSH, POP, JMP, NOP, HLT
  } opcode_t;

  typedef enum logic [2:0] {
    OPD_NONE, REG_A, ADDR_REG_A, ADDR_IMM, IMM, REG_SP, ADDR_REG_SP
  } operand_t;

  typedef enum logic [2:0] {
    RESET_STAGE, FETCH_OPERATION, DECODE, FETCH_IMMEDIATE,
    EXECUTE, WRITE_REGISTER, WRITE_MEMORY
  } stage_t;

  typedef enum logic [1:0] {OP_IDLE, OP_BEGIN, OP_END} op_fetch_t;

  // One WAIT/LOAD pair per operand byte
  typedef enum logic [3:0] {
    FI_IDLE, FI_BEGIN, FI_END,
    FI_WAIT_IMM, FI_LOAD_IMM,
    FI_WAIT_SRC_ADDR, FI_LOAD_SRC_ADDR,
    FI_WAIT_SRC, FI_LOAD_SRC,
    FI_WAIT_DST_ADDR, FI_LOAD_DST_ADDR,
    FI_WAIT_DST, FI_LOAD_DST
  } imm_fetch_t;

  typedef enum logic [1:0] {MW_IDLE, MW_BEGIN, MW_END} mem_write_t;

  typedef enum logic [1:0] {MEM_STAY, MEM_READ, MEM_WRITE} mem_cmd_t;

endpackage

// File: hw/operand_if.sv
`timescale 1ns/10ps

interface operand_if;
  accu_cpu_pkg::byte_t imm;
  accu_cpu_pkg::byte_t mem_src;
  accu_cpu_pkg::byte_t mem_dst;
  // Also the target of the memory write for an [imm] destination
  accu_cpu_pkg::byte_t imm_dst_addr;

  modport fetch (
    output imm,
    output mem_src,
    output mem_dst,
    output imm_dst_addr
  );

  modport exec (
    input imm,
    input mem_src,
    input mem_dst,
    input imm_dst_addr
  );
endinterface

// File: hw/stage_control.sv
`timescale 1ns/10ps

module stage_control (
  input    logic                   CLOCK
  , input  logic                   RESET
  , input  logic                   op_done
  , input  logic                   imm_done
  , input  logic                   write_done
  , input  accu_cpu_pkg::operand_t dst_mode
  , input  accu_cpu_pkg::byte_t    fetch_addr
  , input  accu_cpu_pkg::byte_t    write_addr
  , input  logic                   write_req
  , output accu_cpu_pkg::stage_t   stage
  , output accu_cpu_pkg::byte_t    addr_bus
  , output accu_cpu_pkg::mem_cmd_t ctrl_bus
);
  accu_cpu_pkg::stage_t next_stage;
  logic dst_in_memory;

  assign dst_in_memory = (dst_mode == accu_cpu_pkg::ADDR_REG_A)
                      || (dst_mode == accu_cpu_pkg::ADDR_REG_SP)
                      || (dst_mode == accu_cpu_pkg::ADDR_IMM);

  always_comb begin
    case (stage)
      accu_cpu_pkg::RESET_STAGE:     next_stage = accu_cpu_pkg::FETCH_OPERATION;
      accu_cpu_pkg::FETCH_OPERATION:
        next_stage = op_done ? accu_cpu_pkg::DECODE : accu_cpu_pkg::FETCH_OPERATION;
      accu_cpu_pkg::DECODE:          next_stage = accu_cpu_pkg::FETCH_IMMEDIATE;
      accu_cpu_pkg::FETCH_IMMEDIATE:
        next_stage = imm_done ? accu_cpu_pkg::EXECUTE : accu_cpu_pkg::FETCH_IMMEDIATE;
      accu_cpu_pkg::EXECUTE:         next_stage = accu_cpu_pkg::WRITE_REGISTER;
      // Register-only destinations skip the memory write
      accu_cpu_pkg::WRITE_REGISTER:
        next_stage = dst_in_memory ? accu_cpu_pkg::WRITE_MEMORY
                                   : accu_cpu_pkg::FETCH_OPERATION;
      accu_cpu_pkg::WRITE_MEMORY:
        next_stage = write_done ? accu_cpu_pkg::FETCH_OPERATION : accu_cpu_pkg::WRITE_MEMORY;
      default:                       next_stage = accu_cpu_pkg::FETCH_OPERATION;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      stage <= accu_cpu_pkg::RESET_STAGE;
    end else begin
      stage <= next_stage;
    end
  end

  // Bus address and command follow the stage
  always_comb begin
    case (stage)
      accu_cpu_pkg::FETCH_OPERATION, accu_cpu_pkg::FETCH_IMMEDIATE: begin
        addr_bus = fetch_addr;
        ctrl_bus = accu_cpu_pkg::MEM_READ;
      end
      accu_cpu_pkg::WRITE_MEMORY: begin
        addr_bus = write_addr;
        ctrl_bus = write_req ? accu_cpu_pkg::MEM_WRITE : accu_cpu_pkg::MEM_STAY;
      end
      default: begin
        addr_bus = '0;
        ctrl_bus = accu_cpu_pkg::MEM_STAY;
      end
    endcase
  end
endmodule

// File: hw/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
  input    logic                   CLOCK
  , input  logic                   RESET
  , input  accu_cpu_pkg::stage_t   stage
  , input  accu_cpu_pkg::byte_t    ope
  , output accu_cpu_pkg::opcode_t  decode_ope
  , output accu_cpu_pkg::operand_t src_mode
  , output accu_cpu_pkg::operand_t dst_mode
);
  accu_cpu_pkg::opcode_t  next_ope;
  accu_cpu_pkg::operand_t next_src;
  accu_cpu_pkg::operand_t next_dst;

  // 3-bit operand field, codes 6 and 7 alias 2 and 3
  function automatic accu_cpu_pkg::operand_t mode_of(input logic [2:0] code);
    case (code)
      3'd0:       return accu_cpu_pkg::REG_A;
      3'd1:       return accu_cpu_pkg::ADDR_REG_A;
      3'd2, 3'd6: return accu_cpu_pkg::ADDR_IMM;
      3'd4:       return accu_cpu_pkg::REG_SP;
      3'd5:       return accu_cpu_pkg::ADDR_REG_SP;
      default:    return accu_cpu_pkg::IMM;
    endcase
  endfunction

  always_comb begin
    next_src = accu_cpu_pkg::OPD_NONE;
    next_dst = accu_cpu_pkg::OPD_NONE;
    casez (ope)
      8'b00_???_???: begin
        next_ope = accu_cpu_pkg::MOV;
        next_src = mode_of(ope[2:0]);
        next_dst = mode_of(ope[5:3]);
      end
      8'b01_???_???: begin
        next_ope = accu_cpu_pkg::ADD;
        next_src = mode_of(ope[2:0]);
        next_dst = mode_of(ope[5:3]);
      end
      8'b11_000_???: begin
        next_ope = accu_cpu_pkg::PUSH;
        next_src = mode_of(ope[2:0]);
        next_dst = accu_cpu_pkg::ADDR_REG_SP;
      end
      8'b11_001_???: begin
        next_ope = accu_cpu_pkg::POP;
        next_src = accu_cpu_pkg::ADDR_REG_SP;
        next_dst = mode_of(ope[2:0]);
      end
      8'b11_010_000: begin
        next_ope = accu_cpu_pkg::JMP;
        next_src = accu_cpu_pkg::IMM;
      end
      8'hFE:   next_ope = accu_cpu_pkg::NOP;
      default: next_ope = accu_cpu_pkg::HLT;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      decode_ope <= accu_cpu_pkg::NOP;
      src_mode   <= accu_cpu_pkg::OPD_NONE;
      dst_mode   <= accu_cpu_pkg::OPD_NONE;
    end else if (stage == accu_cpu_pkg::DECODE) begin
      decode_ope <= next_ope;
      src_mode   <= next_src;
      dst_mode   <= next_dst;
    end
  end
endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
  input    logic                   CLOCK
  , input  logic                   RESET
  , input  accu_cpu_pkg::stage_t   stage
  , input  accu_cpu_pkg::byte_t    read_bus
  , input  accu_cpu_pkg::byte_t    ip
  , input  accu_cpu_pkg::byte_t    reg_a
  , input  accu_cpu_pkg::byte_t    reg_sp
  , input  accu_cpu_pkg::operand_t src_mode
  , input  accu_cpu_pkg::operand_t dst_mode
  , output accu_cpu_pkg::byte_t    ope
  , output accu_cpu_pkg::byte_t    fetch_addr
  , output logic                   ip_step
  , output logic                   op_done
  , output logic                   imm_done
  , operand_if.fetch               opd
);
  accu_cpu_pkg::op_fetch_t  op_state, op_next;
  accu_cpu_pkg::imm_fetch_t fi_state, fi_next;
  accu_cpu_pkg::imm_fetch_t src_path, dst_path;
  accu_cpu_pkg::byte_t      src_addr;

  always_comb begin
    op_next = accu_cpu_pkg::OP_IDLE;
    if (stage == accu_cpu_pkg::FETCH_OPERATION) begin
      case (op_state)
        accu_cpu_pkg::OP_IDLE:  op_next = accu_cpu_pkg::OP_BEGIN;
        accu_cpu_pkg::OP_BEGIN: op_next = accu_cpu_pkg::OP_END;
        default:                op_next = accu_cpu_pkg::OP_IDLE;
      endcase
    end
  end

  // First byte to read for each operand, source bytes come first
  always_comb begin
    case (dst_mode)
      accu_cpu_pkg::ADDR_IMM:    dst_path = accu_cpu_pkg::FI_WAIT_DST_ADDR;
      accu_cpu_pkg::ADDR_REG_A,
      accu_cpu_pkg::ADDR_REG_SP: dst_path = accu_cpu_pkg::FI_WAIT_DST;
      default:                   dst_path = accu_cpu_pkg::FI_END;
    endcase
    case (src_mode)
      accu_cpu_pkg::IMM:         src_path = accu_cpu_pkg::FI_WAIT_IMM;
      accu_cpu_pkg::ADDR_IMM:    src_path = accu_cpu_pkg::FI_WAIT_SRC_ADDR;
      accu_cpu_pkg::ADDR_REG_A,
      accu_cpu_pkg::ADDR_REG_SP: src_path = accu_cpu_pkg::FI_WAIT_SRC;
      default:                   src_path = dst_path;
    endcase
  end

  // Armed during DECODE so the stage starts in BEGIN
  always_comb begin
    fi_next = accu_cpu_pkg::FI_IDLE;
    if (stage == accu_cpu_pkg::DECODE) begin
      fi_next = accu_cpu_pkg::FI_BEGIN;
    end else if (stage == accu_cpu_pkg::FETCH_IMMEDIATE) begin
      case (fi_state)
        accu_cpu_pkg::FI_BEGIN:         fi_next = src_path;
        accu_cpu_pkg::FI_WAIT_IMM:      fi_next = accu_cpu_pkg::FI_LOAD_IMM;
        accu_cpu_pkg::FI_WAIT_SRC_ADDR: fi_next = accu_cpu_pkg::FI_LOAD_SRC_ADDR;
        accu_cpu_pkg::FI_LOAD_SRC_ADDR: fi_next = accu_cpu_pkg::FI_WAIT_SRC;
        accu_cpu_pkg::FI_WAIT_SRC:      fi_next = accu_cpu_pkg::FI_LOAD_SRC;
        accu_cpu_pkg::FI_LOAD_IMM,
        accu_cpu_pkg::FI_LOAD_SRC:      fi_next = dst_path;
        accu_cpu_pkg::FI_WAIT_DST_ADDR: fi_next = accu_cpu_pkg::FI_LOAD_DST_ADDR;
        accu_cpu_pkg::FI_LOAD_DST_ADDR: fi_next = accu_cpu_pkg::FI_WAIT_DST;
        accu_cpu_pkg::FI_WAIT_DST:      fi_next = accu_cpu_pkg::FI_LOAD_DST;
        accu_cpu_pkg::FI_LOAD_DST:      fi_next = accu_cpu_pkg::FI_END;
        default:                        fi_next = accu_cpu_pkg::FI_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      op_state <= accu_cpu_pkg::OP_IDLE;
      fi_state <= accu_cpu_pkg::FI_IDLE;
    end else begin
      op_state <= op_next;
      fi_state <= fi_next;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (op_state == accu_cpu_pkg::OP_BEGIN) begin
      ope <= read_bus;
    end
    case (fi_state)
      accu_cpu_pkg::FI_LOAD_IMM:      opd.imm <= read_bus;
      accu_cpu_pkg::FI_LOAD_SRC_ADDR: src_addr <= read_bus;
      accu_cpu_pkg::FI_LOAD_SRC:      opd.mem_src <= read_bus;
      accu_cpu_pkg::FI_LOAD_DST_ADDR: opd.imm_dst_addr <= read_bus;
      accu_cpu_pkg::FI_LOAD_DST:      opd.mem_dst <= read_bus;
      default: ;
    endcase
  end

  always_comb begin
    fetch_addr = ip;
    case (fi_state)
      accu_cpu_pkg::FI_WAIT_SRC, accu_cpu_pkg::FI_LOAD_SRC: begin
        case (src_mode)
          accu_cpu_pkg::ADDR_REG_A:  fetch_addr = reg_a;
          accu_cpu_pkg::ADDR_REG_SP: fetch_addr = reg_sp;
          default:                   fetch_addr = src_addr;
        endcase
      end
      accu_cpu_pkg::FI_WAIT_DST, accu_cpu_pkg::FI_LOAD_DST: begin
        case (dst_mode)
          accu_cpu_pkg::ADDR_REG_A:  fetch_addr = reg_a;
          accu_cpu_pkg::ADDR_REG_SP: fetch_addr = reg_sp;
          default:                   fetch_addr = opd.imm_dst_addr;
        endcase
      end
      default: fetch_addr = ip;
    endcase
  end

  // Opcode byte is stepped over in BEGIN, after decode, so HLT can hold it
  assign ip_step = fi_state inside {accu_cpu_pkg::FI_BEGIN, accu_cpu_pkg::FI_LOAD_IMM,
                                    accu_cpu_pkg::FI_LOAD_SRC_ADDR,
                                    accu_cpu_pkg::FI_LOAD_DST_ADDR};
  assign op_done  = (stage == accu_cpu_pkg::FETCH_OPERATION)
                 && (op_state == accu_cpu_pkg::OP_END);
  assign imm_done = (stage == accu_cpu_pkg::FETCH_IMMEDIATE)
                 && (fi_state == accu_cpu_pkg::FI_END);
endmodule

// File: hw/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
  input    logic                   CLOCK
  , input  logic                   RESET
  , input  accu_cpu_pkg::stage_t   stage
  , input  accu_cpu_pkg::opcode_t  decode_ope
  , input  accu_cpu_pkg::operand_t src_mode
  , input  accu_cpu_pkg::operand_t dst_mode
  , input  accu_cpu_pkg::byte_t    reg_a
  , input  accu_cpu_pkg::byte_t    reg_sp
  , operand_if.exec                opd
  , output accu_cpu_pkg::byte_t    result
  , output accu_cpu_pkg::byte_t    write_bus
  , output accu_cpu_pkg::byte_t    write_addr
  , output logic                   write_req
  , output logic                   write_done
);
  accu_cpu_pkg::byte_t      src_val, dst_val, original_dst;
  accu_cpu_pkg::mem_write_t mw_state;

  always_comb begin
    case (src_mode)
      accu_cpu_pkg::REG_A:  src_val = reg_a;
      accu_cpu_pkg::REG_SP: src_val = reg_sp;
      accu_cpu_pkg::IMM:    src_val = opd.imm;
      accu_cpu_pkg::ADDR_REG_A, accu_cpu_pkg::ADDR_REG_SP,
      accu_cpu_pkg::ADDR_IMM: src_val = opd.mem_src;
      default:              src_val = '0;
    endcase
    case (dst_mode)
      accu_cpu_pkg::REG_A:  dst_val = reg_a;
      accu_cpu_pkg::REG_SP: dst_val = reg_sp;
      accu_cpu_pkg::ADDR_REG_A, accu_cpu_pkg::ADDR_REG_SP,
      accu_cpu_pkg::ADDR_IMM: dst_val = opd.mem_dst;
      default:              dst_val = '0;
    endcase
  end

  // Sum wraps at 8 bits
  always_ff @(posedge CLOCK) begin
    if (stage == accu_cpu_pkg::FETCH_IMMEDIATE) begin
      original_dst <= dst_val;
    end
    if (stage == accu_cpu_pkg::EXECUTE) begin
      case (decode_ope)
        accu_cpu_pkg::ADD: result <= original_dst + src_val;
        accu_cpu_pkg::MOV, accu_cpu_pkg::PUSH, accu_cpu_pkg::POP: result <= src_val;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      mw_state  <= accu_cpu_pkg::MW_IDLE;
      write_bus <= '0;
    end else if (stage == accu_cpu_pkg::WRITE_MEMORY) begin
      case (mw_state)
        accu_cpu_pkg::MW_IDLE: begin
          mw_state  <= accu_cpu_pkg::MW_BEGIN;
          write_bus <= result;
        end
        accu_cpu_pkg::MW_BEGIN: mw_state <= accu_cpu_pkg::MW_END;
        default:                mw_state <= accu_cpu_pkg::MW_IDLE;
      endcase
    end else begin
      mw_state <= accu_cpu_pkg::MW_IDLE;
    end
  end

  always_comb begin
    case (dst_mode)
      accu_cpu_pkg::ADDR_REG_A:  write_addr = reg_a;
      accu_cpu_pkg::ADDR_REG_SP: write_addr = reg_sp;
      accu_cpu_pkg::ADDR_IMM:    write_addr = opd.imm_dst_addr;
      default:                   write_addr = '0;
    endcase
  end

  assign write_req  = (stage == accu_cpu_pkg::WRITE_MEMORY)
                   && (mw_state != accu_cpu_pkg::MW_IDLE);
  assign write_done = (stage == accu_cpu_pkg::WRITE_MEMORY)
                   && (mw_state == accu_cpu_pkg::MW_END);
endmodule

// File: hw/register_file.sv
`timescale 1ns/10ps
`include "accu_cpu_macros.svh"

module register_file (
  input    logic                   CLOCK
  , input  logic                   RESET
  , input  accu_cpu_pkg::stage_t   stage
  , input  accu_cpu_pkg::opcode_t  decode_ope
  , input  accu_cpu_pkg::operand_t dst_mode
  , input  accu_cpu_pkg::byte_t    result
  , input  accu_cpu_pkg::byte_t    imm
  , input  logic                   ip_step
  , output accu_cpu_pkg::byte_t    reg_a
  , output accu_cpu_pkg::byte_t    reg_sp
  , output accu_cpu_pkg::byte_t    ip
);
  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      reg_a  <= '0;
      reg_sp <= `ACCU_STACK_TOP;
    end else if (stage == accu_cpu_pkg::WRITE_REGISTER) begin
      if (dst_mode == accu_cpu_pkg::REG_A) begin
        reg_a <= result;
      end
      // PUSH moves SP before the memory write, POP after the read
      if (dst_mode == accu_cpu_pkg::REG_SP) begin
        reg_sp <= result;
      end else if (decode_ope == accu_cpu_pkg::PUSH) begin
        reg_sp <= reg_sp - accu_cpu_pkg::byte_t'(`ACCU_STACK_UNIT);
      end else if (decode_ope == accu_cpu_pkg::POP) begin
        reg_sp <= reg_sp + accu_cpu_pkg::byte_t'(`ACCU_STACK_UNIT);
      end
    end
  end

  // JMP is relative to the byte after its operand
  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      ip <= '0;
    end else if (decode_ope != accu_cpu_pkg::HLT) begin
      if (ip_step) begin
        ip <= ip + 8'd1;
      end else if (stage == accu_cpu_pkg::EXECUTE && decode_ope == accu_cpu_pkg::JMP) begin
        ip <= ip + imm;
      end
    end
  end
endmodule

// File: hw/accu_cpu.sv
`timescale 1ns/10ps

module accu_cpu (
  input    logic                   CLOCK
  , input  logic                   RESET
  , input  accu_cpu_pkg::byte_t    read_bus
  , output accu_cpu_pkg::mem_cmd_t ctrl_bus
  , output accu_cpu_pkg::byte_t    addr_bus
  , output accu_cpu_pkg::byte_t    write_bus
  , output accu_cpu_pkg::byte_t    out
);
  accu_cpu_pkg::stage_t   stage;
  accu_cpu_pkg::opcode_t  decode_ope;
  accu_cpu_pkg::operand_t src_mode, dst_mode;
  accu_cpu_pkg::byte_t    ope, fetch_addr, write_addr, result;
  accu_cpu_pkg::byte_t    reg_a, reg_sp, ip;
  logic                   op_done, imm_done, write_done, write_req, ip_step;

  operand_if opd ();

  stage_control u_stage_control (.*);

  instr_decoder u_instr_decoder (.*);

  fetch_unit u_fetch_unit (.*, .opd(opd));

  execute_unit u_execute_unit (.*, .opd(opd));

  register_file u_register_file (.*, .imm(opd.imm));

  assign out = reg_a;
endmodule

// File: testbench/accu_cpu_sva.sv
`timescale 1ns/10ps

module accu_cpu_sva (
  input    logic                   CLOCK
  , input  logic                   RESET
  , input  accu_cpu_pkg::stage_t   stage
  , input  accu_cpu_pkg::mem_cmd_t ctrl_bus
  , input  logic                   op_done
  , input  logic                   imm_done
);
  int write_fails = 0;
  int fetch_fails = 0;
  int decode_fails = 0;

  // Bus writes only after the data-load cycle of the memory-write stage
  write_in_stage: assert property (@(posedge CLOCK) disable iff (RESET)
      (ctrl_bus == accu_cpu_pkg::MEM_WRITE)
      |-> ((stage == accu_cpu_pkg::WRITE_MEMORY)
           && ($past(stage) == accu_cpu_pkg::WRITE_MEMORY)))
    else begin
      write_fails++;
      $error("ctrl_bus is MEM_WRITE outside the write cycles of WRITE_MEMORY");
    end

  // Opcode fetch is left on op_done in its third cycle
  fetch_holds: assert property (@(posedge CLOCK) disable iff (RESET)
      ((stage == accu_cpu_pkg::FETCH_OPERATION)
       && ($past(stage) != accu_cpu_pkg::FETCH_OPERATION))
      |-> (!op_done)
      ##1 ((stage == accu_cpu_pkg::FETCH_OPERATION) && !op_done)
      ##1 ((stage == accu_cpu_pkg::FETCH_OPERATION) && op_done)
      ##1 (stage == accu_cpu_pkg::DECODE))
    else begin
      fetch_fails++;
      $error("FETCH_OPERATION not left on op_done in its third cycle");
    end

  decode_single: assert property (@(posedge CLOCK) disable iff (RESET)
      (stage == accu_cpu_pkg::DECODE)
      |=> ((stage == accu_cpu_pkg::FETCH_IMMEDIATE) && !imm_done))
    else begin
      decode_fails++;
      $error("DECODE lasted more than one cycle or operand fetch ended at once");
    end
endmodule

bind stage_control accu_cpu_sva u_stage_checks (
  .CLOCK(CLOCK),
  .RESET(RESET),
  .stage(stage),
  .ctrl_bus(ctrl_bus),
  .op_done(op_done),
  .imm_done(imm_done)
);

// File: testbench/accu_cpu_tb.sv
`timescale 1ns/10ps
`include "accu_cpu_macros.svh"

module accu_cpu_tb;
  localparam int CLOCK_PERIOD = 8;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_TESTS    = 5;
  localparam int PROG_BYTES   = 16;

  // First program byte sits in the top byte
  typedef logic [8*PROG_BYTES-1:0] program_t;

  logic                   CLOCK;
  logic                   RESET;
  accu_cpu_pkg::byte_t    read_bus;
  accu_cpu_pkg::mem_cmd_t ctrl_bus;
  accu_cpu_pkg::byte_t    addr_bus;
  accu_cpu_pkg::byte_t    write_bus;
  accu_cpu_pkg::byte_t    out;

  accu_cpu_pkg::byte_t mem [`ACCU_MEM_DEPTH];
  accu_cpu_pkg::byte_t image [`ACCU_MEM_DEPTH];
  logic                load_req;

  program_t            prog [NUM_TESTS];
  int                  instr_count [NUM_TESTS];
  accu_cpu_pkg::byte_t exp_out [NUM_TESTS];
  accu_cpu_pkg::byte_t check_addr [NUM_TESTS];
  accu_cpu_pkg::byte_t exp_byte [NUM_TESTS];
  string               test_name [NUM_TESTS];

  int error_count;
  int fail_tests;
  int timeout_limit;
  int cycle_count = 0;

  accu_cpu dut (
    .CLOCK(CLOCK),
    .RESET(RESET),
    .read_bus(read_bus),
    .ctrl_bus(ctrl_bus),
    .addr_bus(addr_bus),
    .write_bus(write_bus),
    .out(out)
  );

  initial begin
    CLOCK = 1'b0;
    forever #(CLOCK_PERIOD / 2) CLOCK = ~CLOCK;
  end

  // Memory model with combinational read and a write at the clock edge
  assign read_bus = mem[addr_bus];

  always @(posedge CLOCK) begin
    if (load_req) begin
      mem <= image;
    end else if (ctrl_bus == accu_cpu_pkg::MEM_WRITE) begin
      mem[addr_bus] <= write_bus;
    end
  end

  always @(posedge CLOCK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: the run went past its limit of %0d cycles", timeout_limit);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic int assertion_failures();
    return dut.u_stage_control.u_stage_checks.write_fails
         + dut.u_stage_control.u_stage_checks.fetch_fails
         + dut.u_stage_control.u_stage_checks.decode_fails;
  endfunction

  task automatic next_cycles(input int n);
    repeat (n) @(posedge CLOCK);
    #DRIVE_DELAY;
  endtask

  task automatic check_value(input string what, input accu_cpu_pkg::byte_t got,
                             input accu_cpu_pkg::byte_t expected);
    if (got !== expected) begin
      $display("MISMATCH at time %0t: %s is %02h, expected %02h", $time, what, got, expected);
      error_count++;
    end
  endtask

  task automatic add_test(input int t, input string name, input program_t code,
                          input int count, input accu_cpu_pkg::byte_t out_value,
                          input accu_cpu_pkg::byte_t addr, input accu_cpu_pkg::byte_t value);
    test_name[t]   = name;
    prog[t]        = code;
    instr_count[t] = count;
    exp_out[t]     = out_value;
    check_addr[t]  = addr;
    exp_byte[t]    = value;
  endtask

  task automatic build_table();
    accu_cpu_pkg::byte_t r1;
    accu_cpu_pkg::byte_t r2;
    accu_cpu_pkg::byte_t stack_slot;
    r1 = accu_cpu_pkg::byte_t'($urandom);
    r2 = accu_cpu_pkg::byte_t'($urandom);
    stack_slot = accu_cpu_pkg::byte_t'(`ACCU_STACK_TOP - `ACCU_STACK_UNIT);
    // Programs without memory writes must leave byte 00 as loaded
    add_test(0, "mov_imm", {8'h03, 8'hA7, {14{8'hFF}}}, 2, 8'hA7, 8'h00, 8'h03);
    add_test(1, "add_imm", {8'h43, r1, 8'h43, r2, {12{8'hFF}}}, 3,
             accu_cpu_pkg::byte_t'((int'(r1) + int'(r2)) % 256), 8'h00, 8'h43);
    // A to [80], then [80] to [81], then [81] back to A
    add_test(2, "mov_mem", {8'h03, 8'h5C, 8'h10, 8'h80, 8'h03, 8'h00, 8'h12, 8'h80,
                            8'h81, 8'h02, 8'h81, {5{8'hFF}}}, 6, 8'h5C, 8'h81, 8'h5C);
    add_test(3, "push_pop", {8'hC3, 8'h3E, 8'hC8, {13{8'hFF}}}, 3, 8'h3E, stack_slot, 8'h3E);
    add_test(4, "jmp_skip", {8'h03, 8'h11, 8'hD0, 8'h02, 8'h03, 8'h99, {10{8'hFF}}}, 3,
             8'h11, 8'h00, 8'h03);
  endtask

  task automatic run_test(input int t);
    int i;
    int errors_before;
    int asserts_before;
    errors_before  = error_count;
    asserts_before = assertion_failures();
    for (i = 0; i < `ACCU_MEM_DEPTH; i++) begin
      image[i] = accu_cpu_pkg::byte_t'(i) ^ 8'h5A;
    end
    for (i = 0; i < PROG_BYTES; i++) begin
      image[i] = prog[t][8*(PROG_BYTES-1-i) +: 8];
    end
    RESET    = 1'b1;
    load_req = 1'b1;
    next_cycles(1);
    load_req = 1'b0;
    next_cycles(RESET_CYCLES - 1);
    // Bus is idle and write data cleared while in reset
    check_value("ctrl_bus in reset", accu_cpu_pkg::byte_t'(ctrl_bus),
                accu_cpu_pkg::byte_t'(accu_cpu_pkg::MEM_STAY));
    check_value("write_bus in reset", write_bus, 8'h00);
    RESET = 1'b0;
    next_cycles(instr_count[t] * `ACCU_MAX_INSTR_CYCLES);
    check_value("out", out, exp_out[t]);
    check_value($sformatf("mem[%02h]", check_addr[t]), mem[check_addr[t]], exp_byte[t]);
    if (error_count == errors_before && assertion_failures() == asserts_before) begin
      $display("Test %0d %s: ok", t, test_name[t]);
    end else begin
      $display("Test %0d %s: FAILED", t, test_name[t]);
      fail_tests++;
    end
  endtask

  initial begin : main
    int t;
    RESET       = 1'b1;
    load_req    = 1'b0;
    error_count = 0;
    fail_tests  = 0;
    void'($urandom(32'h3b03_5925));
    build_table();
    timeout_limit = 100;
    for (t = 0; t < NUM_TESTS; t++) begin
      timeout_limit += instr_count[t] * `ACCU_MAX_INSTR_CYCLES;
    end
    for (t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d mismatches, %0d assertion failures",
             NUM_TESTS, NUM_TESTS - fail_tests, fail_tests, error_count,
             assertion_failures());
    if (error_count == 0 && fail_tests == 0 && assertion_failures() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end
endmodule

// File: accu_cpu.f
+incdir+hw
hw/accu_cpu_pkg.sv
hw/operand_if.sv
hw/stage_control.sv
hw/instr_decoder.sv
hw/fetch_unit.sv
hw/execute_unit.sv
hw/register_file.sv
hw/accu_cpu.sv
testbench/accu_cpu_sva.sv
testbench/accu_cpu_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= accu_cpu_tb
FILELIST   ?= accu_cpu.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
